//--- src/sysflit_pkg.sv
package sysflit_pkg;

    localparam int NUM_NODES = 4;
    localparam int NODE_IDX_W = $clog2(NUM_NODES);
    localparam int HEARTBEAT_PERIOD = 64;

    typedef logic [7:0] node_id_t;
    typedef logic [NODE_IDX_W-1:0] node_idx_t;
    typedef logic [$clog2(HEARTBEAT_PERIOD)-1:0] hb_count_t;

    localparam node_id_t ROOT_ID = 8'h00;
    localparam node_id_t BROADCAST_ID = 8'hff;
    localparam node_id_t TEMP_ID_BASE = 8'h20;
    localparam node_id_t FIRST_CHILD_ID = 8'h01;

    typedef enum logic [7:0] {
        DATA,
        SYSTEM
    } flit_type_e;

    typedef enum logic [7:0] {
        S_PARENT_REQUEST,
        S_PARENT_ACK,
        S_JOIN_REQUEST,
        S_JOIN_ACK,
        S_HEARTBEAT,
        S_SEARCH_FUNCTION,
        S_SEARCH_FUNCTION_ACK,
        S_DEBUG
    } system_header_e;

    typedef enum logic [3:0] {
        I_GENERATE_PARENT_REQUEST,
        I_WAIT_PARENT_ACK,
        I_GENERATE_JOIN_REQUEST,
        I_WAIT_JOIN_ACK,
        S_GENERATE_PARENT_REQUEST,
        S_WAIT_PARENT_ACK,
        S_GENERATE_JOIN_REQUEST,
        S_WAIT_JOIN_ACK,
        NORMAL,
        FATAL_ERROR
    } routing_state_e;

    // is_init sits in the msb of every 32-bit payload view
    typedef struct packed {
        logic is_init;
        logic [30:0] reserved;
    } parent_request_t;

    typedef struct packed {
        logic is_init;
        logic [30:0] reserved;
    } parent_ack_t;

    typedef struct packed {
        logic is_init;
        node_id_t parent_id;
        node_id_t child_id;
        logic [14:0] reserved;
    } join_request_t;

    typedef struct packed {
        node_id_t parent_id;
        node_id_t current_child_id;
        node_id_t child_id;
        logic [7:0] reserved;
    } join_ack_t;

    typedef union packed {
        parent_request_t parent_request;
        parent_ack_t parent_ack;
        join_request_t join_request;
        join_ack_t join_ack;
    } system_payload_t;

    typedef struct packed {
        flit_type_e flittype;
        node_id_t src_id;
        node_id_t dst_id;
    } flit_header_t;

    typedef struct packed {
        system_header_e header;
        system_payload_t payload;
    } system_part_t;

    typedef struct packed {
        flit_header_t header;
        system_part_t system;
    } flit_t;

endpackage

//--- src/system_flit_generator_comb.sv
`timescale 1ns/1ps

module system_flit_generator_comb (
    input sysflit_pkg::flit_t sys_flit,
    input logic sys_flit_valid,
    input sysflit_pkg::routing_state_e routing_state,
    input sysflit_pkg::node_id_t global_destination_id,
    input sysflit_pkg::node_id_t temporal_id,
    input sysflit_pkg::node_id_t parent_id,
    input sysflit_pkg::node_id_t this_node_id,
    input sysflit_pkg::node_id_t node_id_counter,
    input logic is_heartbeat_request,
    input logic is_root,
    input logic is_init,
    input logic is_join_ack_parent,
    output logic update_node_id_counter,
    output logic next_routing_state_valid,
    output sysflit_pkg::routing_state_e next_routing_state,
    output logic flit_out_valid,
    output sysflit_pkg::flit_t flit_out
);
    import sysflit_pkg::*;

    system_header_e in_header;
    system_payload_t in_payload;

    assign in_header = sys_flit.system.header;
    assign in_payload = sys_flit.system.payload;

    always_comb begin
        flit_out_valid = 1'b0;
        flit_out = '0;
        flit_out.header.flittype = SYSTEM;
        flit_out.header.src_id = this_node_id;
        update_node_id_counter = 1'b0;
        next_routing_state_valid = 1'b0;
        next_routing_state = FATAL_ERROR;
        case (routing_state)
            I_GENERATE_PARENT_REQUEST: begin
                flit_out_valid = 1'b1;
                flit_out.header.src_id = temporal_id;
                flit_out.header.dst_id = BROADCAST_ID;
                flit_out.system.header = S_PARENT_REQUEST;
                flit_out.system.payload.parent_request.is_init = 1'b1;
                next_routing_state_valid = 1'b1;
                next_routing_state = I_WAIT_PARENT_ACK;
            end
            I_WAIT_PARENT_ACK: begin
                // first ack wins
                if (sys_flit_valid && in_header == S_PARENT_ACK) begin
                    next_routing_state_valid = 1'b1;
                    next_routing_state = I_GENERATE_JOIN_REQUEST;
                end
            end
            I_GENERATE_JOIN_REQUEST: begin
                flit_out_valid = 1'b1;
                flit_out.header.src_id = temporal_id;
                flit_out.header.dst_id = parent_id;
                flit_out.system.header = S_JOIN_REQUEST;
                flit_out.system.payload.join_request.is_init = 1'b1;
                flit_out.system.payload.join_request.parent_id = parent_id;
                flit_out.system.payload.join_request.child_id = temporal_id;
                next_routing_state_valid = 1'b1;
                next_routing_state = I_WAIT_JOIN_ACK;
            end
            I_WAIT_JOIN_ACK: begin
                if (sys_flit_valid && in_header == S_JOIN_ACK &&
                        in_payload.join_ack.current_child_id == temporal_id) begin
                    next_routing_state_valid = 1'b1;
                    next_routing_state = NORMAL;
                end
            end
            NORMAL: begin
                if (sys_flit_valid) begin
                    case (in_header)
                        S_PARENT_REQUEST: begin
                            flit_out_valid = 1'b1;
                            flit_out.header.dst_id = global_destination_id;
                            flit_out.system.header = S_PARENT_ACK;
                            flit_out.system.payload.parent_ack.is_init = is_init;
                        end
                        S_JOIN_REQUEST: begin
                            flit_out_valid = 1'b1;
                            if (is_root) begin
                                flit_out.header.dst_id = global_destination_id;
                                flit_out.system.header = S_JOIN_ACK;
                                flit_out.system.payload.join_ack.parent_id =
                                    in_payload.join_request.parent_id;
                                flit_out.system.payload.join_ack.current_child_id =
                                    in_payload.join_request.child_id;
                                if (is_init) begin
                                    flit_out.system.payload.join_ack.child_id = node_id_counter;
                                    update_node_id_counter = 1'b1;
                                end else begin
                                    flit_out.system.payload.join_ack.child_id =
                                        in_payload.join_request.child_id;
                                end
                            end else begin
                                // relay toward the root
                                flit_out.header.dst_id = parent_id;
                                flit_out.system.header = S_JOIN_REQUEST;
                                flit_out.system.payload = in_payload;
                            end
                        end
                        S_JOIN_ACK: begin
                            flit_out_valid = 1'b1;
                            flit_out.system.header = S_JOIN_ACK;
                            flit_out.system.payload = in_payload;
                            if (is_join_ack_parent) begin
                                flit_out.header.dst_id = global_destination_id;
                            end else begin
                                flit_out.header.dst_id = in_payload.join_ack.current_child_id;
                            end
                        end
                        default: begin
                        end
                    endcase
                end else if (is_heartbeat_request) begin
                    flit_out_valid = 1'b1;
                    flit_out.header.dst_id = parent_id;
                    flit_out.system.header = S_HEARTBEAT;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

//--- src/node_controller.sv
`timescale 1ns/1ps

module node_controller #(
    parameter int NODE_INDEX = 0
) (
    input logic clk,
    input logic rst_n,
    input sysflit_pkg::flit_t bcast_flit,
    input logic bcast_valid,
    output logic take_ready,
    output sysflit_pkg::flit_t reply_flit,
    output logic reply_valid,
    input logic reply_ready,
    output logic joined
);
    import sysflit_pkg::*;

    routing_state_e routing_state, next_routing_state;
    node_id_t this_node_id, parent_id, node_id_counter, temporal_id;
    hb_count_t hb_count;
    flit_t in_flit_q, flit_out;
    logic in_valid_q, slot_free, gen_state, consume, take, addressed;
    logic is_root, is_init, is_join_ack_parent, heartbeat_request;
    logic update_node_id_counter, next_routing_state_valid, flit_out_valid;

    assign is_root = (NODE_INDEX == 0);
    assign temporal_id = TEMP_ID_BASE + node_id_t'(NODE_INDEX);
    assign joined = (routing_state == NORMAL);

    assign slot_free = !reply_valid;
    assign gen_state = (routing_state == I_GENERATE_PARENT_REQUEST) ||
                       (routing_state == I_GENERATE_JOIN_REQUEST);
    // generate states leave the held flit for the next cycle
    assign consume = slot_free && !gen_state;
    assign take_ready = slot_free && !(in_valid_q && gen_state);
    assign take = bcast_valid && take_ready;

    assign addressed = (bcast_flit.header.dst_id == BROADCAST_ID) ||
                       (bcast_flit.header.dst_id == this_node_id) ||
                       (bcast_flit.header.dst_id == temporal_id);

    // same msb in every payload view
    assign is_init = in_flit_q.system.payload.parent_request.is_init;
    assign is_join_ack_parent = (in_flit_q.system.payload.join_ack.parent_id == this_node_id);
    assign heartbeat_request = joined && !is_root && (hb_count == '0);

    system_flit_generator_comb generator_inst (
        .sys_flit                 (in_flit_q),
        .sys_flit_valid           (in_valid_q),
        .routing_state            (routing_state),
        .global_destination_id    (in_flit_q.header.src_id),
        .temporal_id              (temporal_id),
        .parent_id                (parent_id),
        .this_node_id             (this_node_id),
        .node_id_counter          (node_id_counter),
        .is_heartbeat_request     (heartbeat_request),
        .is_root                  (is_root),
        .is_init                  (is_init),
        .is_join_ack_parent       (is_join_ack_parent),
        .update_node_id_counter   (update_node_id_counter),
        .next_routing_state_valid (next_routing_state_valid),
        .next_routing_state       (next_routing_state),
        .flit_out_valid           (flit_out_valid),
        .flit_out                 (flit_out)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            routing_state <= is_root ? NORMAL : I_GENERATE_PARENT_REQUEST;
            this_node_id <= is_root ? ROOT_ID : temporal_id;
            parent_id <= ROOT_ID;
            node_id_counter <= FIRST_CHILD_ID;
            hb_count <= hb_count_t'(HEARTBEAT_PERIOD - 1);
            in_valid_q <= 1'b0;
            reply_valid <= 1'b0;
        end else begin
            if (take) begin
                in_valid_q <= addressed;
            end else if (consume) begin
                in_valid_q <= 1'b0;
            end
            if (slot_free) begin
                reply_valid <= flit_out_valid;
            end else if (reply_ready) begin
                reply_valid <= 1'b0;
            end
            if (slot_free && next_routing_state_valid) begin
                routing_state <= next_routing_state;
                // ids latched as the acks arrive
                if (routing_state == I_WAIT_PARENT_ACK) begin
                    parent_id <= in_flit_q.header.src_id;
                end
                if (routing_state == I_WAIT_JOIN_ACK) begin
                    this_node_id <= in_flit_q.system.payload.join_ack.child_id;
                end
            end
            if (slot_free && update_node_id_counter) begin
                node_id_counter <= node_id_counter + 8'd1;
            end
            if (slot_free && heartbeat_request && !in_valid_q) begin
                hb_count <= hb_count_t'(HEARTBEAT_PERIOD - 1);
            end else if (joined && hb_count != '0) begin
                hb_count <= hb_count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            in_flit_q <= bcast_flit;
        end
        if (slot_free && flit_out_valid) begin
            reply_flit <= flit_out;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) routing_state != FATAL_ERROR);

endmodule

//--- src/flit_dispatcher.sv
`timescale 1ns/1ps

module flit_dispatcher (
    input logic clk,
    input logic rst_n,
    input sysflit_pkg::flit_t in_flit,
    input logic in_valid,
    output logic in_ready,
    output sysflit_pkg::flit_t bcast_flit,
    output logic [sysflit_pkg::NUM_NODES-1:0] bcast_valid,
    input logic [sysflit_pkg::NUM_NODES-1:0] take_ready
);
    import sysflit_pkg::*;

    logic [NUM_NODES-1:0] pending;
    logic accept;

    // next flit only once every node has its copy
    assign in_ready = ~|pending;
    assign accept = in_valid && in_ready;
    assign bcast_valid = pending;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= '0;
        end else if (accept) begin
            pending <= '1;
        end else begin
            pending <= pending & ~take_ready;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            bcast_flit <= in_flit;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        |pending |=> $stable(bcast_flit));

endmodule

//--- src/flit_arbiter.sv
`timescale 1ns/1ps

module flit_arbiter (
    input logic clk,
    input logic rst_n,
    input sysflit_pkg::flit_t reply_flit [sysflit_pkg::NUM_NODES],
    input logic [sysflit_pkg::NUM_NODES-1:0] reply_valid,
    output logic [sysflit_pkg::NUM_NODES-1:0] reply_ready,
    output sysflit_pkg::flit_t out_flit,
    output logic out_valid,
    input logic out_ready
);
    import sysflit_pkg::*;

    node_idx_t last_q, grant_idx;
    logic grant_valid, slot_free;

    assign slot_free = !out_valid || out_ready;

    // search starts just after the last winner
    always_comb begin
        grant_valid = 1'b0;
        grant_idx = last_q;
        for (int i = 1; i <= NUM_NODES; i++) begin
            if (!grant_valid && reply_valid[(int'(last_q) + i) % NUM_NODES]) begin
                grant_valid = 1'b1;
                grant_idx = node_idx_t'((int'(last_q) + i) % NUM_NODES);
            end
        end
    end

    always_comb begin
        reply_ready = '0;
        if (grant_valid && slot_free) begin
            reply_ready[grant_idx] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            last_q <= node_idx_t'(NUM_NODES - 1);
        end else if (slot_free) begin
            out_valid <= grant_valid;
            if (grant_valid) begin
                last_q <= grant_idx;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (slot_free && grant_valid) begin
            out_flit <= reply_flit[grant_idx];
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_flit));

endmodule

//--- src/sysflit_top.sv
`timescale 1ns/1ps

module sysflit_top (
    input logic clk,
    input logic rst_n,
    input sysflit_pkg::flit_t in_flit,
    input logic in_valid,
    output logic in_ready,
    output sysflit_pkg::flit_t out_flit,
    output logic out_valid,
    input logic out_ready,
    output logic [sysflit_pkg::NUM_NODES-1:0] joined
);
    import sysflit_pkg::*;

    flit_t bcast_flit;
    flit_t reply_flit [NUM_NODES];
    logic [NUM_NODES-1:0] bcast_valid, take_ready, reply_valid, reply_ready;

    flit_dispatcher dispatcher_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_flit     (in_flit),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .bcast_flit  (bcast_flit),
        .bcast_valid (bcast_valid),
        .take_ready  (take_ready)
    );

    // node 0 comes up as root
    for (genvar i = 0; i < NUM_NODES; i++) begin : g_node
        node_controller #(
            .NODE_INDEX (i)
        ) node_inst (
            .clk         (clk),
            .rst_n       (rst_n),
            .bcast_flit  (bcast_flit),
            .bcast_valid (bcast_valid[i]),
            .take_ready  (take_ready[i]),
            .reply_flit  (reply_flit[i]),
            .reply_valid (reply_valid[i]),
            .reply_ready (reply_ready[i]),
            .joined      (joined[i])
        );
    end

    flit_arbiter arbiter_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .reply_flit  (reply_flit),
        .reply_valid (reply_valid),
        .reply_ready (reply_ready),
        .out_flit    (out_flit),
        .out_valid   (out_valid),
        .out_ready   (out_ready)
    );

endmodule

//--- dv/sysflit_tb.sv
`timescale 1ns/1ps

module sysflit_tb;
    import sysflit_pkg::*;

    typedef struct {
        node_id_t src;
        node_id_t dst;
        system_header_e hdr;
        logic is_init;
        node_id_t parent;
        node_id_t child;
        system_header_e exp_hdr;
        node_id_t exp_dst;
        node_id_t exp_child;
        logic [NUM_NODES-1:0] exp_srcs;
        bit use_counter;
    } dir_row_t;

    localparam int N_ROWS = 6;
    localparam int WAIT_LIMIT = 4000;

    logic clk = 1'b0;
    logic rst_n;
    flit_t in_flit;
    logic in_valid;
    logic in_ready;
    flit_t out_flit;
    logic out_valid;
    logic out_ready;
    logic [NUM_NODES-1:0] joined;

    dir_row_t table_rows [N_ROWS];
    flit_t tx_q[$];
    flit_t rx_q[$];
    flit_t exp_q[$];
    node_id_t parent_of [NUM_NODES];
    node_id_t next_child;
    logic [255:0] bp_pattern;
    logic [7:0] cyc;
    bit loopback;
    bit bp_mode;
    int errors;

    sysflit_top sysflit_top_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_flit   (in_flit),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_flit  (out_flit),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .joined    (joined)
    );

    always #10 clk = ~clk;

    // monitor, loopback path and input driver in one process
    always @(posedge clk) begin
        if (rst_n) begin
            cyc <= cyc + 8'd1;
            if (out_valid && out_ready) begin
                rx_q.push_back(out_flit);
                if (loopback) begin
                    tx_q.push_back(out_flit);
                end
            end
            if (in_valid && in_ready) begin
                tx_q.delete(0);
            end
            in_valid <= (tx_q.size() != 0);
            if (tx_q.size() != 0) begin
                in_flit <= tx_q[0];
            end
            out_ready <= !bp_mode || bp_pattern[cyc];
        end
    end

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("** Error: %s expected 0x%0h, got 0x%0h", name, expected, actual);
        end
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("timeout while waiting for %s", what);
    endtask

    function automatic flit_t make_flit(input node_id_t src, input node_id_t dst,
            input system_header_e hdr, input logic is_init, input node_id_t parent,
            input node_id_t child);
        flit_t f;
        f = '0;
        f.header.flittype = SYSTEM;
        f.header.src_id = src;
        f.header.dst_id = dst;
        f.system.header = hdr;
        if (hdr == S_JOIN_REQUEST) begin
            f.system.payload.join_request.is_init = is_init;
            f.system.payload.join_request.parent_id = parent;
            f.system.payload.join_request.child_id = child;
        end else if (hdr == S_PARENT_ACK) begin
            f.system.payload.parent_ack.is_init = is_init;
        end else begin
            f.system.payload.parent_request.is_init = is_init;
        end
        return f;
    endfunction

    function automatic flit_t make_join_ack(input node_id_t src, input node_id_t dst,
            input node_id_t parent, input node_id_t current, input node_id_t child);
        flit_t f;
        f = '0;
        f.header.flittype = SYSTEM;
        f.header.src_id = src;
        f.header.dst_id = dst;
        f.system.header = S_JOIN_ACK;
        f.system.payload.join_ack.parent_id = parent;
        f.system.payload.join_ack.current_child_id = current;
        f.system.payload.join_ack.child_id = child;
        return f;
    endfunction

    function automatic flit_t expected_reply(input dir_row_t row, input node_id_t src);
        if (row.exp_hdr == S_JOIN_ACK) begin
            return make_join_ack(src, row.exp_dst, row.parent, row.child,
                                 row.use_counter ? next_child : row.exp_child);
        end
        return make_flit(src, row.exp_dst, row.exp_hdr, row.is_init, 8'h00, 8'h00);
    endfunction

    function automatic int count_replies();
        int n;
        n = 0;
        foreach (rx_q[i]) begin
            if (rx_q[i].system.header != S_HEARTBEAT) begin
                n++;
            end
        end
        return n;
    endfunction

    task automatic compare_flit(input flit_t expected, input flit_t actual);
        check_value("out_flit.flittype", expected.header.flittype, actual.header.flittype);
        check_value("out_flit.src_id", expected.header.src_id, actual.header.src_id);
        check_value("out_flit.dst_id", expected.header.dst_id, actual.header.dst_id);
        check_value("out_flit.system.header", expected.system.header, actual.system.header);
        check_value("out_flit.system.payload", expected.system.payload, actual.system.payload);
    endtask

    task automatic wait_idle();
        int limit;
        int quiet;
        limit = 0;
        quiet = 0;
        while (quiet < 10 && limit < WAIT_LIMIT) begin
            @(negedge clk);
            limit++;
            if (tx_q.size() == 0 && !out_valid && in_ready) begin
                quiet++;
            end else begin
                quiet = 0;
            end
        end
        if (quiet < 10) begin
            report_timeout("the flit loop to drain");
        end
    endtask

    // final delivery of each join ack goes to a temporary id
    task automatic check_join_acks();
        bit child_seen [NUM_NODES];
        join_ack_t ack;
        int n_acks;
        n_acks = 0;
        foreach (child_seen[i]) begin
            child_seen[i] = 1'b0;
            parent_of[i] = BROADCAST_ID;
        end
        foreach (rx_q[i]) begin
            ack = rx_q[i].system.payload.join_ack;
            if (rx_q[i].system.header == S_JOIN_ACK && rx_q[i].header.dst_id >= TEMP_ID_BASE &&
                    rx_q[i].header.dst_id < TEMP_ID_BASE + NUM_NODES) begin
                n_acks++;
                check_value("join_ack.current_child_id", rx_q[i].header.dst_id,
                            ack.current_child_id);
                if (ack.child_id < FIRST_CHILD_ID || ack.child_id >= NUM_NODES ||
                        child_seen[ack.child_id]) begin
                    errors++;
                    $display("** Error: join_ack.child_id unexpected value 0x%0h", ack.child_id);
                end else begin
                    child_seen[ack.child_id] = 1'b1;
                    parent_of[ack.child_id] = ack.parent_id;
                end
            end
        end
        check_value("join ack count", NUM_NODES - 1, n_acks);
    endtask

    task automatic run_table();
        int limit;
        bit found;
        rx_q.delete();
        exp_q.delete();
        foreach (table_rows[r]) begin
            tx_q.push_back(make_flit(table_rows[r].src, table_rows[r].dst, table_rows[r].hdr,
                                     table_rows[r].is_init, table_rows[r].parent,
                                     table_rows[r].child));
            for (int s = 0; s < NUM_NODES; s++) begin
                if (table_rows[r].exp_srcs[s]) begin
                    exp_q.push_back(expected_reply(table_rows[r], node_id_t'(s)));
                end
            end
            if (table_rows[r].use_counter) begin
                next_child++;
            end
        end
        limit = 0;
        while ((count_replies() < exp_q.size() || tx_q.size() != 0) && limit < WAIT_LIMIT) begin
            @(negedge clk);
            limit++;
        end
        if (count_replies() < exp_q.size()) begin
            report_timeout("directed replies");
        end
        // extra or late replies would land here
        repeat (60) @(negedge clk);
        foreach (rx_q[i]) begin
            if (rx_q[i].system.header != S_HEARTBEAT) begin
                found = 1'b0;
                for (int k = 0; k < exp_q.size() && !found; k++) begin
                    if (exp_q[k].header.src_id == rx_q[i].header.src_id) begin
                        found = 1'b1;
                        compare_flit(exp_q[k], rx_q[i]);
                        exp_q.delete(k);
                    end
                end
                if (!found) begin
                    errors++;
                    $display("** Error: out_flit.src_id unexpected value 0x%0h",
                             rx_q[i].header.src_id);
                end
            end
        end
        foreach (exp_q[k]) begin
            errors++;
            $display("expected reply from source %0h never arrived", exp_q[k].header.src_id);
        end
    endtask

    task automatic check_heartbeats();
        bit seen [NUM_NODES];
        bit all_seen;
        int limit;
        rx_q.delete();
        all_seen = 1'b0;
        limit = 0;
        while (!all_seen && limit < WAIT_LIMIT) begin
            @(negedge clk);
            limit++;
            foreach (seen[i]) begin
                seen[i] = (i == 0);
            end
            foreach (rx_q[i]) begin
                if (rx_q[i].system.header == S_HEARTBEAT && rx_q[i].header.src_id < NUM_NODES &&
                        rx_q[i].header.dst_id == parent_of[rx_q[i].header.src_id]) begin
                    seen[rx_q[i].header.src_id] = 1'b1;
                end
            end
            all_seen = 1'b1;
            foreach (seen[i]) begin
                all_seen = all_seen && seen[i];
            end
        end
        if (!all_seen) begin
            report_timeout("a heartbeat from every child node");
        end
        foreach (rx_q[i]) begin
            if (rx_q[i].system.header == S_HEARTBEAT && rx_q[i].header.src_id == ROOT_ID) begin
                errors++;
                $display("root node sent a heartbeat");
            end
        end
    endtask

    initial begin
        int limit;
        errors = 0;
        loopback = 1'b0;
        bp_mode = 1'b0;
        cyc = '0;
        rst_n = 1'b0;
        in_valid = 1'b0;
        in_flit = '0;
        out_ready = 1'b1;
        bp_pattern[31:0] = $urandom(32'hb674ca5c);
        for (int i = 1; i < 8; i++) begin
            bp_pattern[i*32 +: 32] = $urandom;
        end
        // src, dst, header, is_init, parent, child, then expected header, dst, child,
        // sources and counter flag
        table_rows[0] = '{8'h40, BROADCAST_ID, S_PARENT_REQUEST, 1'b1, 8'h00, 8'h00,
                          S_PARENT_ACK, 8'h40, 8'h00, 4'hf, 1'b0};
        table_rows[1] = '{8'h41, ROOT_ID, S_JOIN_REQUEST, 1'b1, ROOT_ID, 8'h41,
                          S_JOIN_ACK, 8'h41, 8'h00, 4'h1, 1'b1};
        table_rows[2] = '{8'h42, ROOT_ID, S_JOIN_REQUEST, 1'b0, ROOT_ID, 8'h37,
                          S_JOIN_ACK, 8'h42, 8'h37, 4'h1, 1'b0};
        table_rows[3] = '{8'h43, 8'h55, S_PARENT_REQUEST, 1'b1, 8'h00, 8'h00,
                          S_PARENT_ACK, 8'h43, 8'h00, 4'h0, 1'b0};
        table_rows[4] = '{8'h44, BROADCAST_ID, S_PARENT_REQUEST, 1'b0, 8'h00, 8'h00,
                          S_PARENT_ACK, 8'h44, 8'h00, 4'hf, 1'b0};
        table_rows[5] = '{8'h45, ROOT_ID, S_JOIN_REQUEST, 1'b1, ROOT_ID, 8'h45,
                          S_JOIN_ACK, 8'h45, 8'h00, 4'h1, 1'b1};

        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("out_valid", 64'h0, out_valid);
        // root is up from reset
        check_value("joined", 64'h1, joined);
        check_value("in_ready", 64'h1, in_ready);

        loopback = 1'b1;
        limit = 0;
        while (joined !== '1 && limit < WAIT_LIMIT) begin
            @(negedge clk);
            limit++;
        end
        if (joined !== '1) begin
            report_timeout("all nodes to join");
        end
        wait_idle();
        loopback = 1'b0;
        check_join_acks();
        next_child = node_id_t'(NUM_NODES);

        run_table();
        check_heartbeats();
        bp_mode = 1'b1;
        run_table();
        bp_mode = 1'b0;

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- sysflit.f
src/sysflit_pkg.sv
src/system_flit_generator_comb.sv
src/node_controller.sv
src/flit_dispatcher.sv
src/flit_arbiter.sv
src/sysflit_top.sv
dv/sysflit_tb.sv

//--- Bender.yml
package:
  name: sysflit

sources:
  - src/sysflit_pkg.sv
  - src/system_flit_generator_comb.sv
  - src/node_controller.sv
  - src/flit_dispatcher.sv
  - src/flit_arbiter.sv
  - src/sysflit_top.sv
  - target: test
    files:
      - dv/sysflit_tb.sv
